// File: design/decode_config.svh
`ifndef DECODE_CONFIG_SVH
`define DECODE_CONFIG_SVH

////////////////////////////////////////////////////////////
// Field widths
////////////////////////////////////////////////////////////

// Full instruction word
`define INSTR_W 18

// ALU opcode and register select fields
`define OPF_W 4

// Immediate and memory address
`define DATA_W 16

// Absolute address field of the flow group
`define ADDR_IMM_W 14

////////////////////////////////////////////////////////////
// Special registers
////////////////////////////////////////////////////////////

// Both sit behind the second register write port
`define SP_REG 13
`define FP_REG 12

`endif

// File: design/decodePkg.sv
`include "decode_config.svh"

package decodePkg;

	// Instruction form, decided once by the classifier
	typedef enum logic [2:0] {
		clsAluReg,
		clsMemMove,
		clsAluImm,
		clsFlow,
		clsStack,
		clsStep,
		clsIllegal
	} instClass_t;

	// Codes 0 and 1 in bits 15:12 select the register and memory forms
	typedef enum logic [`OPF_W-1:0] {
		aluRegForm = 4'd0,
		aluMemForm = 4'd1,
		aluAdd = 4'd2,
		aluSub = 4'd3,
		aluAnd = 4'd4,
		aluOr = 4'd5,
		aluXor = 4'd6,
		aluNot = 4'd7,
		aluLsh = 4'd8,
		aluRsh = 4'd9,
		aluArsh = 4'd10,
		aluCmp = 4'd11,
		aluCmpr = 4'd12,
		aluMul = 4'd13,
		aluFmul = 4'd14,
		aluMovr = 4'd15
	} aluOp_t;

	typedef enum logic [3:0] {
		memMovmr = 4'd0,
		memMovrm = 4'd1
	} memOp_t;

	// Bits 17:14 of the flow and stack groups
	typedef enum logic [3:0] {
		specCall = 4'd4,
		specMovmri = 4'd5,
		specMovrmi = 4'd6,
		specRet = 4'd7,
		specJl = 4'd8,
		specJle = 4'd9,
		specJne = 4'd10,
		specJe = 4'd11,
		specPop = 4'd12,
		specPush = 4'd13,
		specPushi = 4'd14
	} specOp_t;

	typedef enum logic [5:0] {
		stepIncr = 6'd60,
		stepDecr = 6'd61
	} stepOp_t;

	typedef struct packed {
		logic low;
		logic negative;
		logic zero;
	} flags_t;

	// Datapath bus steering, immToOperand in bit 0
	typedef struct packed {
		logic stepUp;
		logic stepDown;
		logic stepToBus2;
		logic stepToBus1;
		logic pcIncrement;
		logic pcFromAddr;
		logic pcFromMem;
		logic memToBus2;
		logic memToBus1;
		logic dataFromReg;
		logic addrFromImm;
		logic addrFromReg;
		logic regToBus2;
		logic regToBus1;
		logic immToBus2;
		logic immToBus1;
		logic aluToBus2;
		logic aluToBus1;
		logic regToOperand;
		logic immToOperand;
	} bufCtrl_t;

	// FP and SP can only be written through port 2
	function automatic logic isPort2Reg(input logic [`OPF_W-1:0] regNum);
		return (regNum == `OPF_W'(`SP_REG)) || (regNum == `OPF_W'(`FP_REG));
	endfunction

endpackage

// File: design/ctrlBundleIf.sv
`timescale 1ns/1ps
`include "decode_config.svh"

interface ctrlBundleIf;
	import decodePkg::*;

	aluOp_t aluOp;
	logic writeEn1;
	logic writeEn2;
	logic [`DATA_W-1:0] immediate;
	bufCtrl_t bufCtrl;
	logic [`OPF_W-1:0] destSel;
	logic [`OPF_W-1:0] destSel2;
	logic [`OPF_W-1:0] srcSel;
	logic flagWrite;
	logic memWrite;
	logic memRead;
	logic [`DATA_W-1:0] addr;

	modport decoder (output aluOp, writeEn1, writeEn2, immediate, bufCtrl, destSel,
		destSel2, srcSel, flagWrite, memWrite, memRead, addr);

	modport sink (input aluOp, writeEn1, writeEn2, immediate, bufCtrl, destSel,
		destSel2, srcSel, flagWrite, memWrite, memRead, addr);

endinterface

// File: design/instrClassifier.sv
`timescale 1ns/1ps
`include "decode_config.svh"

module instrClassifier (
	input logic [`INSTR_W-1:0] instruction,
	output decodePkg::instClass_t instClass,
	output logic immForm
);
	import decodePkg::*;

	always_comb begin
		if (instruction[17:16] == 2'b00) begin
			// Normal forms, split on the upper opcode field
			if (instruction[15:12] == 4'b0000) begin
				instClass = clsAluReg;
			end else if (instruction[15:12] == 4'b0001) begin
				instClass = clsMemMove;
			end else begin
				instClass = clsAluImm;
			end
		end else if (instruction[17:16] == 2'b01 || instruction[17:16] == 2'b10) begin
			// 14-bit absolute address group
			instClass = clsFlow;
		end else if (instruction[17:14] inside {4'b1100, 4'b1101, 4'b1110}) begin
			instClass = clsStack;
		end else if (instruction[17:14] == 4'b1111) begin
			instClass = clsStep;
		end else begin
			instClass = clsIllegal;
		end
	end

	// Tells the ALU decoder where its opcode and source come from
	assign immForm = (instClass == clsAluImm);

endmodule

// File: design/aluOpDecoder.sv
`timescale 1ns/1ps
`include "decode_config.svh"

module aluOpDecoder (
	input logic [`INSTR_W-1:0] instruction,
	input logic immForm,
	ctrlBundleIf.decoder bundle
);
	import decodePkg::*;

	aluOp_t opcode;
	logic [`OPF_W-1:0] dest;
	logic toPort2;
	logic knownOp;

	assign opcode = aluOp_t'(immForm ? instruction[15:12] : instruction[7:4]);
	assign dest = instruction[11:8];
	assign toPort2 = isPort2Reg(dest);
	assign knownOp = opcode inside {[aluAdd:aluCmpr], aluMovr};

	always_comb begin
		bundle.aluOp = aluRegForm;
		bundle.writeEn1 = 1'b0;
		bundle.writeEn2 = 1'b0;
		bundle.immediate = '0;
		bundle.bufCtrl = '0;
		bundle.bufCtrl.pcIncrement = 1'b1;
		bundle.destSel = '0;
		bundle.destSel2 = '0;
		bundle.srcSel = '0;
		bundle.flagWrite = 1'b0;
		bundle.memWrite = 1'b0;
		bundle.memRead = 1'b0;
		bundle.addr = '0;

		if (knownOp) begin
			bundle.aluOp = opcode;
			bundle.destSel = dest;
			bundle.destSel2 = dest;
			// Immediate form operates on its own destination
			bundle.srcSel = immForm ? dest : instruction[3:0];
			bundle.immediate = immForm ? `DATA_W'(instruction[7:0]) : '0;
			bundle.bufCtrl.immToOperand = immForm;
			bundle.bufCtrl.regToOperand = ~immForm;
		end

		case (opcode)
			aluAdd, aluSub, aluAnd, aluOr, aluXor, aluNot, aluLsh, aluRsh, aluArsh: begin
				bundle.flagWrite = 1'b1;
				bundle.writeEn1 = ~toPort2;
				bundle.writeEn2 = toPort2;
				bundle.bufCtrl.aluToBus1 = ~toPort2;
				bundle.bufCtrl.aluToBus2 = toPort2;
			end
			// Compares only update the flags
			aluCmp, aluCmpr: bundle.flagWrite = 1'b1;
			aluMovr: begin
				bundle.writeEn1 = ~toPort2;
				bundle.writeEn2 = toPort2;
				bundle.bufCtrl.regToBus1 = ~immForm & ~toPort2;
				bundle.bufCtrl.regToBus2 = ~immForm & toPort2;
				bundle.bufCtrl.immToBus1 = immForm & ~toPort2;
				bundle.bufCtrl.immToBus2 = immForm & toPort2;
			end
			default: ;
		endcase
	end

endmodule

// File: design/memOpDecoder.sv
`timescale 1ns/1ps
`include "decode_config.svh"

module memOpDecoder (
	input logic [`INSTR_W-1:0] instruction,
	ctrlBundleIf.decoder bundle
);
	import decodePkg::*;

	memOp_t op;
	logic [`OPF_W-1:0] dest;
	logic toPort2;
	logic knownOp;

	assign op = memOp_t'(instruction[7:4]);
	assign dest = instruction[11:8];
	assign toPort2 = isPort2Reg(dest);
	assign knownOp = op inside {memMovmr, memMovrm};

	always_comb begin
		bundle.aluOp = aluRegForm;
		bundle.writeEn1 = 1'b0;
		bundle.writeEn2 = 1'b0;
		bundle.immediate = '0;
		bundle.bufCtrl = '0;
		bundle.bufCtrl.pcIncrement = 1'b1;
		bundle.destSel = '0;
		bundle.destSel2 = '0;
		bundle.srcSel = '0;
		bundle.flagWrite = 1'b0;
		bundle.memWrite = 1'b0;
		bundle.memRead = 1'b0;
		bundle.addr = '0;

		// Address always comes from the source register
		if (knownOp) begin
			bundle.destSel = dest;
			bundle.destSel2 = dest;
			bundle.srcSel = instruction[3:0];
			bundle.bufCtrl.regToOperand = 1'b1;
			bundle.bufCtrl.addrFromReg = 1'b1;
		end

		case (op)
			memMovmr: begin
				bundle.memRead = 1'b1;
				bundle.writeEn1 = ~toPort2;
				bundle.writeEn2 = toPort2;
				bundle.bufCtrl.memToBus1 = ~toPort2;
				bundle.bufCtrl.memToBus2 = toPort2;
			end
			memMovrm: begin
				bundle.memWrite = 1'b1;
				bundle.bufCtrl.dataFromReg = 1'b1;
			end
			default: ;
		endcase
	end

endmodule

// File: design/flowDecoder.sv
`timescale 1ns/1ps
`include "decode_config.svh"

module flowDecoder (
	input logic [`INSTR_W-1:0] instruction,
	input decodePkg::flags_t flags,
	ctrlBundleIf.decoder bundle
);
	import decodePkg::*;

	specOp_t op;
	logic knownOp;
	logic jumpTaken;

	assign op = specOp_t'(instruction[17:14]);
	assign knownOp = op inside {[specCall:specJe]};

	// Branch condition, only looked at for the four jumps
	always_comb begin
		case (op)
			specJl: jumpTaken = flags.low | flags.negative;
			specJle: jumpTaken = flags.low | flags.negative | flags.zero;
			specJne: jumpTaken = ~flags.zero;
			specJe: jumpTaken = flags.zero;
			default: jumpTaken = 1'b0;
		endcase
	end

	always_comb begin
		bundle.aluOp = aluRegForm;
		bundle.writeEn1 = 1'b0;
		bundle.writeEn2 = 1'b0;
		bundle.immediate = '0;
		bundle.bufCtrl = '0;
		bundle.bufCtrl.pcIncrement = 1'b1;
		bundle.destSel = '0;
		bundle.destSel2 = '0;
		bundle.srcSel = '0;
		bundle.flagWrite = 1'b0;
		bundle.memWrite = 1'b0;
		bundle.memRead = 1'b0;
		bundle.addr = '0;

		if (knownOp) begin
			// Absolute address taken straight from the instruction
			bundle.addr = `DATA_W'(instruction[`ADDR_IMM_W-1:0]);
			// Register 15 receives absolute loads
			bundle.destSel = `OPF_W'(15);
			bundle.bufCtrl.regToOperand = 1'b1;
			bundle.bufCtrl.addrFromImm = 1'b1;
		end

		case (op)
			specCall: begin
				bundle.memWrite = 1'b1;
				bundle.bufCtrl.memToBus1 = 1'b1;
				bundle.bufCtrl.addrFromReg = 1'b1;
			end
			specMovmri: begin
				bundle.memRead = 1'b1;
				bundle.writeEn1 = 1'b1;
				bundle.bufCtrl.memToBus1 = 1'b1;
			end
			specMovrmi: begin
				bundle.memWrite = 1'b1;
				bundle.bufCtrl.dataFromReg = 1'b1;
			end
			// Return address is read back from memory
			specRet: begin
				bundle.memRead = 1'b1;
				bundle.bufCtrl.pcFromMem = 1'b1;
				bundle.bufCtrl.pcIncrement = 1'b0;
			end
			specJl, specJle, specJne, specJe: begin
				bundle.bufCtrl.pcFromAddr = jumpTaken;
				bundle.bufCtrl.pcIncrement = ~jumpTaken;
			end
			default: ;
		endcase
	end

endmodule

// File: design/stackDecoder.sv
`timescale 1ns/1ps
`include "decode_config.svh"

module stackDecoder (
	input logic [`INSTR_W-1:0] instruction,
	ctrlBundleIf.decoder bundle
);
	import decodePkg::*;

	specOp_t stackOp;
	stepOp_t stepOp;
	logic [`OPF_W-1:0] stackReg;
	logic [`OPF_W-1:0] stepReg;
	logic stepPort2;
	logic knownStack;
	logic knownStep;

	assign stackOp = specOp_t'(instruction[17:14]);
	assign stepOp = stepOp_t'(instruction[17:12]);
	assign stackReg = instruction[13:10];
	assign stepReg = instruction[11:8];
	assign stepPort2 = isPort2Reg(stepReg);
	assign knownStack = stackOp inside {specPop, specPush, specPushi};
	assign knownStep = stepOp inside {stepIncr, stepDecr};

	always_comb begin
		bundle.aluOp = aluRegForm;
		bundle.writeEn1 = 1'b0;
		bundle.writeEn2 = 1'b0;
		bundle.immediate = '0;
		bundle.bufCtrl = '0;
		bundle.bufCtrl.pcIncrement = 1'b1;
		bundle.destSel = '0;
		bundle.destSel2 = '0;
		bundle.srcSel = '0;
		bundle.flagWrite = 1'b0;
		bundle.memWrite = 1'b0;
		bundle.memRead = 1'b0;
		bundle.addr = '0;

		////////////////////////////////////////////////////////////
		// POP, PUSH, PUSHI
		////////////////////////////////////////////////////////////
		if (knownStack) begin
			// SP addresses memory and is updated through port 2
			bundle.srcSel = `OPF_W'(`SP_REG);
			bundle.destSel2 = `OPF_W'(`SP_REG);
			bundle.bufCtrl.addrFromReg = 1'b1;
			bundle.bufCtrl.dataFromReg = 1'b1;
		end

		case (stackOp)
			specPop: begin
				// Popping into FP or SP would corrupt the frame
				if (!isPort2Reg(stackReg)) begin
					bundle.memRead = 1'b1;
					bundle.writeEn1 = 1'b1;
					bundle.writeEn2 = 1'b1;
					bundle.destSel = stackReg;
					bundle.bufCtrl.regToOperand = 1'b1;
					bundle.bufCtrl.stepToBus2 = 1'b1;
					bundle.bufCtrl.stepDown = 1'b1;
				end
			end
			specPush: begin
				bundle.memWrite = 1'b1;
				bundle.writeEn2 = 1'b1;
				bundle.destSel = stackReg;
				bundle.bufCtrl.regToOperand = 1'b1;
				bundle.bufCtrl.stepToBus2 = 1'b1;
				bundle.bufCtrl.stepUp = 1'b1;
			end
			specPushi: begin
				bundle.memWrite = 1'b1;
				bundle.writeEn2 = 1'b1;
				bundle.bufCtrl.immToOperand = 1'b1;
				bundle.bufCtrl.stepToBus2 = 1'b1;
				bundle.bufCtrl.stepUp = 1'b1;
			end
			default: ;
		endcase

		////////////////////////////////////////////////////////////
		// INCR, DECR
		////////////////////////////////////////////////////////////
		if (knownStep) begin
			bundle.srcSel = stepReg;
			bundle.destSel = stepReg;
			bundle.destSel2 = stepReg;
			bundle.writeEn1 = ~stepPort2;
			bundle.writeEn2 = stepPort2;
			bundle.bufCtrl.stepToBus1 = ~stepPort2;
			bundle.bufCtrl.stepToBus2 = stepPort2;
			bundle.bufCtrl.stepUp = (stepOp == stepIncr);
			bundle.bufCtrl.stepDown = (stepOp == stepDecr);
		end
	end

endmodule

// File: design/ctrlRegister.sv
`timescale 1ns/1ps
`include "decode_config.svh"

module ctrlRegister (
	input logic clk,
	input logic rst,
	input decodePkg::instClass_t instClass,
	ctrlBundleIf.sink aluBundle,
	ctrlBundleIf.sink memBundle,
	ctrlBundleIf.sink flowBundle,
	ctrlBundleIf.sink stackBundle,
	output logic [`OPF_W-1:0] aluOp,
	output logic writeEn1,
	output logic writeEn2,
	output logic [`DATA_W-1:0] immediate,
	output decodePkg::bufCtrl_t bufCtrl,
	output logic [`OPF_W-1:0] destSel,
	output logic [`OPF_W-1:0] destSel2,
	output logic [`OPF_W-1:0] srcSel,
	output logic flagWrite,
	output logic memWrite,
	output logic memRead,
	output logic [`DATA_W-1:0] addr
);
	import decodePkg::*;

	// Four selects, immediate and address, steering, five strobes
	localparam int WORD_W = 4 * `OPF_W + 2 * `DATA_W + $bits(bufCtrl_t) + 5;

	logic [WORD_W-1:0] aluWord;
	logic [WORD_W-1:0] memWord;
	logic [WORD_W-1:0] flowWord;
	logic [WORD_W-1:0] stackWord;
	logic [WORD_W-1:0] nextWord;
	logic [WORD_W-1:0] wordQ;

	assign aluWord = {aluBundle.aluOp, aluBundle.writeEn1, aluBundle.writeEn2,
		aluBundle.immediate, aluBundle.bufCtrl, aluBundle.destSel, aluBundle.destSel2,
		aluBundle.srcSel, aluBundle.flagWrite, aluBundle.memWrite, aluBundle.memRead,
		aluBundle.addr};
	assign memWord = {memBundle.aluOp, memBundle.writeEn1, memBundle.writeEn2,
		memBundle.immediate, memBundle.bufCtrl, memBundle.destSel, memBundle.destSel2,
		memBundle.srcSel, memBundle.flagWrite, memBundle.memWrite, memBundle.memRead,
		memBundle.addr};
	assign flowWord = {flowBundle.aluOp, flowBundle.writeEn1, flowBundle.writeEn2,
		flowBundle.immediate, flowBundle.bufCtrl, flowBundle.destSel, flowBundle.destSel2,
		flowBundle.srcSel, flowBundle.flagWrite, flowBundle.memWrite, flowBundle.memRead,
		flowBundle.addr};
	assign stackWord = {stackBundle.aluOp, stackBundle.writeEn1, stackBundle.writeEn2,
		stackBundle.immediate, stackBundle.bufCtrl, stackBundle.destSel,
		stackBundle.destSel2, stackBundle.srcSel, stackBundle.flagWrite,
		stackBundle.memWrite, stackBundle.memRead, stackBundle.addr};

	always_comb begin
		case (instClass)
			clsAluReg, clsAluImm: nextWord = aluWord;
			clsMemMove: nextWord = memWord;
			clsFlow: nextWord = flowWord;
			clsStack, clsStep: nextWord = stackWord;
			default: nextWord = '0;
		endcase
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			wordQ <= '0;
		end else begin
			wordQ <= nextWord;
		end
	end

	assign {aluOp, writeEn1, writeEn2, immediate, bufCtrl, destSel, destSel2, srcSel,
		flagWrite, memWrite, memRead, addr} = wordQ;

endmodule

// File: design/controlUnit.sv
`timescale 1ns/1ps
`include "decode_config.svh"

module controlUnit (
	input logic clk,
	input logic rst,
	input logic [`INSTR_W-1:0] instruction,
	input decodePkg::flags_t flags,
	output logic [`OPF_W-1:0] aluOp,
	output logic writeEn1,
	output logic writeEn2,
	output logic [`DATA_W-1:0] immediate,
	output decodePkg::bufCtrl_t bufCtrl,
	output logic [`OPF_W-1:0] destSel,
	output logic [`OPF_W-1:0] destSel2,
	output logic [`OPF_W-1:0] srcSel,
	output logic flagWrite,
	output logic memWrite,
	output logic memRead,
	output logic [`DATA_W-1:0] addr
);
	import decodePkg::*;

	instClass_t instClass;
	logic immForm;

	// One control word per instruction group
	ctrlBundleIf aluBundle ();
	ctrlBundleIf memBundle ();
	ctrlBundleIf flowBundle ();
	ctrlBundleIf stackBundle ();

	instrClassifier classifier (
		.instruction(instruction),
		.instClass(instClass),
		.immForm(immForm)
	);

	aluOpDecoder aluDec (
		.instruction(instruction),
		.immForm(immForm),
		.bundle(aluBundle.decoder)
	);

	memOpDecoder memDec (
		.instruction(instruction),
		.bundle(memBundle.decoder)
	);

	flowDecoder flowDec (
		.instruction(instruction),
		.flags(flags),
		.bundle(flowBundle.decoder)
	);

	stackDecoder stackDec (
		.instruction(instruction),
		.bundle(stackBundle.decoder)
	);

	// Output stage, one cycle after the instruction
	ctrlRegister outReg (
		.clk(clk),
		.rst(rst),
		.instClass(instClass),
		.aluBundle(aluBundle.sink),
		.memBundle(memBundle.sink),
		.flowBundle(flowBundle.sink),
		.stackBundle(stackBundle.sink),
		.aluOp(aluOp),
		.writeEn1(writeEn1),
		.writeEn2(writeEn2),
		.immediate(immediate),
		.bufCtrl(bufCtrl),
		.destSel(destSel),
		.destSel2(destSel2),
		.srcSel(srcSel),
		.flagWrite(flagWrite),
		.memWrite(memWrite),
		.memRead(memRead),
		.addr(addr)
	);

endmodule

// File: dv/controlUnit_checker.sv
`timescale 1ns/1ps
`include "decode_config.svh"

module controlUnit_checker (
	input logic clk,
	input logic rst,
	input logic [`INSTR_W-1:0] instruction,
	input decodePkg::flags_t flags,
	input logic [`OPF_W-1:0] aluOp,
	input logic writeEn1,
	input logic writeEn2,
	input logic [`DATA_W-1:0] immediate,
	input decodePkg::bufCtrl_t bufCtrl,
	input logic [`OPF_W-1:0] destSel,
	input logic [`OPF_W-1:0] destSel2,
	input logic [`OPF_W-1:0] srcSel,
	input logic flagWrite,
	input logic memWrite,
	input logic memRead,
	input logic [`DATA_W-1:0] addr
);
	import decodePkg::*;

	logic [`INSTR_W-1:0] instrQ;
	flags_t flagsQ;
	logic rstQ = 1'b1;
	logic validQ = 1'b0;
	logic active;
	logic [3:0] hi4;
	logic [3:0] f15;
	logic [3:0] f7;
	logic [3:0] dst;
	logic [3:0] stackReg;
	logic [3:0] aluCode;
	logic [5:0] step6;
	logic isAlu;
	logic isAluImm;
	logic isMem;
	logic isFlow;
	logic isStack;
	logic isStep;
	logic aluKnown;
	logic stepKnown;
	logic srcKnown;
	logic destKnown;
	logic p2Dst;
	logic expWe1;
	logic expWe2;
	logic expFlag;
	logic expRd;
	logic expWr;
	logic expJump;
	logic [`OPF_W-1:0] expAluOp;
	logic [`OPF_W-1:0] expSrc;
	logic [`DATA_W-1:0] expImm;
	logic [24:0] resetWord;
	int failCount = 0;

	// Instruction and flags of the previous edge
	always @(posedge clk) begin
		instrQ <= instruction;
		flagsQ <= flags;
		rstQ <= rst;
		validQ <= 1'b1;
	end

	////////////////////////////////////////////////////////////
	// Reference decode of the registered instruction
	////////////////////////////////////////////////////////////

	assign active = validQ && !rstQ;
	assign hi4 = instrQ[17:14];
	assign f15 = instrQ[15:12];
	assign f7 = instrQ[7:4];
	assign dst = instrQ[11:8];
	assign stackReg = instrQ[13:10];
	assign step6 = instrQ[17:12];
	assign isAlu = (instrQ[17:16] == 2'b00) && (f15 != 4'd1);
	assign isAluImm = (instrQ[17:16] == 2'b00) && (f15 >= 4'd2);
	assign isMem = (instrQ[17:16] == 2'b00) && (f15 == 4'd1);
	assign isFlow = (instrQ[17:16] == 2'b01) || (instrQ[17:16] == 2'b10);
	assign isStack = (hi4 >= 4'd12) && (hi4 <= 4'd14);
	assign isStep = (hi4 == 4'd15);
	assign aluCode = isAluImm ? f15 : f7;
	assign aluKnown = ((aluCode >= 4'd2) && (aluCode <= 4'd12)) || (aluCode == 4'd15);
	assign stepKnown = isStep && ((step6 == 6'd60) || (step6 == 6'd61));
	// Register selects of the decoded register forms
	assign srcKnown = (isAlu && aluKnown) || (isMem && f7 <= 4'd1);
	assign destKnown = srcKnown || stepKnown;
	assign expSrc = isAluImm ? dst : instrQ[3:0];
	// FP and SP go through the second port
	assign p2Dst = (dst == 4'd12) || (dst == 4'd13);
	assign expAluOp = aluKnown ? aluCode : 4'd0;
	assign expImm = (isAluImm && aluKnown) ? `DATA_W'(instrQ[7:0]) : '0;
	assign resetWord = {writeEn1, writeEn2, flagWrite, memRead, memWrite, bufCtrl};

	always_comb begin
		expWe1 = 1'b0;
		expWe2 = 1'b0;
		expFlag = 1'b0;
		expRd = 1'b0;
		expWr = 1'b0;
		expJump = 1'b0;
		if (isAlu) begin
			if (aluCode >= 4'd2 && aluCode <= 4'd10) begin
				expFlag = 1'b1;
				expWe1 = !p2Dst;
				expWe2 = p2Dst;
			end else if (aluCode == 4'd11 || aluCode == 4'd12) begin
				expFlag = 1'b1;
			end else if (aluCode == 4'd15) begin
				expWe1 = !p2Dst;
				expWe2 = p2Dst;
			end
		end
		if (isMem && f7 == 4'd0) begin
			expRd = 1'b1;
			expWe1 = !p2Dst;
			expWe2 = p2Dst;
		end
		if (isMem && f7 == 4'd1) begin
			expWr = 1'b1;
		end
		if (isFlow) begin
			case (hi4)
				4'd4, 4'd6: expWr = 1'b1;
				4'd5: begin
					expRd = 1'b1;
					expWe1 = 1'b1;
				end
				4'd7: expRd = 1'b1;
				4'd8: expJump = flagsQ.low | flagsQ.negative;
				4'd9: expJump = flagsQ.low | flagsQ.negative | flagsQ.zero;
				4'd10: expJump = !flagsQ.zero;
				4'd11: expJump = flagsQ.zero;
				default: ;
			endcase
		end
		// POP into FP or SP is dropped
		if (isStack && hi4 == 4'd12 && stackReg != 4'd12 && stackReg != 4'd13) begin
			expRd = 1'b1;
			expWe1 = 1'b1;
			expWe2 = 1'b1;
		end
		if (isStack && hi4 != 4'd12) begin
			expWr = 1'b1;
			expWe2 = 1'b1;
		end
		if (stepKnown) begin
			expWe1 = !p2Dst;
			expWe2 = p2Dst;
		end
	end

	////////////////////////////////////////////////////////////
	// Assertions
	////////////////////////////////////////////////////////////

	resetZeroChk: assert property (@(posedge clk) (validQ && rstQ) |-> (resetWord == '0))
		else begin
			failCount++;
			$error("[ERROR] %0t strobes and bufCtrl expected %h actual %h",
				$time, 25'h0, resetWord);
		end

	we1Chk: assert property (@(posedge clk) active |-> (writeEn1 == expWe1))
		else begin
			failCount++;
			$error("[ERROR] %0t writeEn1 expected %0b actual %0b", $time, expWe1, writeEn1);
		end

	we2Chk: assert property (@(posedge clk) active |-> (writeEn2 == expWe2))
		else begin
			failCount++;
			$error("[ERROR] %0t writeEn2 expected %0b actual %0b", $time, expWe2, writeEn2);
		end

	flagChk: assert property (@(posedge clk) active |-> (flagWrite == expFlag))
		else begin
			failCount++;
			$error("[ERROR] %0t flagWrite expected %0b actual %0b", $time, expFlag, flagWrite);
		end

	readChk: assert property (@(posedge clk) active |-> (memRead == expRd))
		else begin
			failCount++;
			$error("[ERROR] %0t memRead expected %0b actual %0b", $time, expRd, memRead);
		end

	writeChk: assert property (@(posedge clk) active |-> (memWrite == expWr))
		else begin
			failCount++;
			$error("[ERROR] %0t memWrite expected %0b actual %0b", $time, expWr, memWrite);
		end

	aluOpChk: assert property (@(posedge clk) (active && isAlu) |-> (aluOp == expAluOp))
		else begin
			failCount++;
			$error("[ERROR] %0t aluOp expected %0d actual %0d", $time, expAluOp, aluOp);
		end

	immChk: assert property (@(posedge clk) (active && isAlu) |-> (immediate == expImm))
		else begin
			failCount++;
			$error("[ERROR] %0t immediate expected %h actual %h", $time, expImm, immediate);
		end

	destSelChk: assert property (@(posedge clk) (active && destKnown) |-> (destSel == dst))
		else begin
			failCount++;
			$error("[ERROR] %0t destSel expected %0d actual %0d", $time, dst, destSel);
		end

	srcSelChk: assert property (@(posedge clk) (active && srcKnown) |-> (srcSel == expSrc))
		else begin
			failCount++;
			$error("[ERROR] %0t srcSel expected %0d actual %0d", $time, expSrc, srcSel);
		end

	addrChk: assert property (@(posedge clk)
		(active && isFlow) |-> (addr == `DATA_W'(instrQ[13:0])))
		else begin
			failCount++;
			$error("[ERROR] %0t addr expected %h actual %h",
				$time, `DATA_W'(instrQ[13:0]), addr);
		end

	jumpChk: assert property (@(posedge clk)
		(active && isFlow) |-> (bufCtrl.pcFromAddr == expJump))
		else begin
			failCount++;
			$error("[ERROR] %0t pcFromAddr expected %0b actual %0b",
				$time, expJump, bufCtrl.pcFromAddr);
		end

	pushChk: assert property (@(posedge clk)
		(active && isStack && hi4 != 4'd12) |-> (destSel2 == `OPF_W'(13)))
		else begin
			failCount++;
			$error("[ERROR] %0t destSel2 expected 13 actual %0d", $time, destSel2);
		end

	stepChk: assert property (@(posedge clk) (active && stepKnown) |->
		({bufCtrl.stepUp, bufCtrl.stepDown} == {step6 == 6'd60, step6 == 6'd61}))
		else begin
			failCount++;
			$error("[ERROR] %0t stepUp,stepDown expected %b%b actual %b%b", $time,
				step6 == 6'd60, step6 == 6'd61, bufCtrl.stepUp, bufCtrl.stepDown);
		end

endmodule

// File: dv/controlUnitTb.sv
`timescale 1ns/1ps
`include "decode_config.svh"

module controlUnitTb;
	import decodePkg::*;

	localparam int RESET_CYC = 8;
	localparam int RAND_CYC = 300;
	// Reset, directed phases, random phase and drain
	localparam int STIM_CYC = RESET_CYC + 48 + 42 + 6 + 64 + 48 + 32 + 32 + RAND_CYC + 2;
	localparam int CYCLE_LIMIT = 2 * STIM_CYC;

	logic clk;
	logic rst;
	logic [`INSTR_W-1:0] instruction;
	flags_t flags;
	logic [`OPF_W-1:0] aluOp;
	logic writeEn1;
	logic writeEn2;
	logic [`DATA_W-1:0] immediate;
	bufCtrl_t bufCtrl;
	logic [`OPF_W-1:0] destSel;
	logic [`OPF_W-1:0] destSel2;
	logic [`OPF_W-1:0] srcSel;
	logic flagWrite;
	logic memWrite;
	logic memRead;
	logic [`DATA_W-1:0] addr;
	int cycleCount = 0;
	int phaseCount = 0;
	int failures;
	// A plain register and both port 2 registers
	logic [`OPF_W-1:0] dstList [3] = '{4'd3, 4'd12, 4'd13};

	controlUnit dut (
		.clk(clk),
		.rst(rst),
		.instruction(instruction),
		.flags(flags),
		.aluOp(aluOp),
		.writeEn1(writeEn1),
		.writeEn2(writeEn2),
		.immediate(immediate),
		.bufCtrl(bufCtrl),
		.destSel(destSel),
		.destSel2(destSel2),
		.srcSel(srcSel),
		.flagWrite(flagWrite),
		.memWrite(memWrite),
		.memRead(memRead),
		.addr(addr)
	);

	bind controlUnit controlUnit_checker outCheck (
		.clk(clk),
		.rst(rst),
		.instruction(instruction),
		.flags(flags),
		.aluOp(aluOp),
		.writeEn1(writeEn1),
		.writeEn2(writeEn2),
		.immediate(immediate),
		.bufCtrl(bufCtrl),
		.destSel(destSel),
		.destSel2(destSel2),
		.srcSel(srcSel),
		.flagWrite(flagWrite),
		.memWrite(memWrite),
		.memRead(memRead),
		.addr(addr)
	);

	initial begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	always @(posedge clk) begin
		cycleCount <= cycleCount + 1;
		if (cycleCount >= CYCLE_LIMIT) begin
			$display("Timeout after %0d cycles, stimulus did not complete", cycleCount);
			$display("tests failed");
			$finish;
		end
	end

	function automatic flags_t randomFlags();
		return flags_t'(3'($urandom));
	endfunction

	// One instruction per cycle on the falling edge
	task automatic sendInstr(input logic [`INSTR_W-1:0] instr, input flags_t fl);
		@(negedge clk);
		instruction = instr;
		flags = fl;
	endtask

	task automatic reportPhase(input string name);
		phaseCount++;
		$display("Phase %-14s done, assertion failures so far: %0d",
			name, dut.outCheck.failCount);
	endtask

	////////////////////////////////////////////////////////////
	// Stimulus
	////////////////////////////////////////////////////////////

	initial begin
		void'($urandom(32'h4659_2921));
		rst = 1'b1;
		instruction = '0;
		flags = '0;

		// Random words while in reset must not reach the outputs
		repeat (RESET_CYC - 1) sendInstr(`INSTR_W'($urandom), randomFlags());
		@(negedge clk);
		rst = 1'b0;
		instruction = `INSTR_W'($urandom);
		reportPhase("reset");

		foreach (dstList[d]) begin
			for (int op = 0; op < 16; op++) begin
				sendInstr({6'b000000, dstList[d], 4'(op), 4'($urandom)}, randomFlags());
			end
		end
		reportPhase("ALU register");

		foreach (dstList[d]) begin
			for (int op = 2; op < 16; op++) begin
				sendInstr({2'b00, 4'(op), dstList[d], 8'($urandom)}, randomFlags());
			end
		end
		reportPhase("ALU immediate");

		foreach (dstList[d]) begin
			for (int op = 0; op < 2; op++) begin
				sendInstr({6'b000001, dstList[d], 4'(op), 4'($urandom)}, randomFlags());
			end
		end
		reportPhase("memory move");

		// Every jump against every flag combination
		for (int code = 4; code < 12; code++) begin
			for (int f = 0; f < 8; f++) begin
				sendInstr({4'(code), 14'($urandom)}, flags_t'(3'(f)));
			end
		end
		reportPhase("flow");

		for (int code = 12; code < 15; code++) begin
			for (int r = 0; r < 16; r++) begin
				sendInstr({4'(code), 4'(r), 10'($urandom)}, randomFlags());
			end
		end
		reportPhase("stack");

		for (int code = 60; code < 62; code++) begin
			for (int r = 0; r < 16; r++) begin
				sendInstr({6'(code), 4'(r), 8'($urandom)}, randomFlags());
			end
		end
		reportPhase("step");

		// MUL and FMUL, unknown memory moves, unknown step codes
		for (int op = 13; op < 15; op++) begin
			foreach (dstList[d]) begin
				sendInstr({6'b000000, dstList[d], 4'(op), 4'($urandom)}, randomFlags());
				sendInstr({2'b00, 4'(op), dstList[d], 8'($urandom)}, randomFlags());
			end
		end
		for (int op = 2; op < 16; op++) begin
			sendInstr({6'b000001, 4'($urandom), 4'(op), 4'($urandom)}, randomFlags());
		end
		for (int code = 62; code < 64; code++) begin
			foreach (dstList[d]) begin
				sendInstr({6'(code), dstList[d], 8'($urandom)}, randomFlags());
			end
		end
		reportPhase("unused codes");

		repeat (RAND_CYC) sendInstr(`INSTR_W'($urandom), randomFlags());
		reportPhase("random");

		// Let the last word pass the output register
		repeat (2) @(negedge clk);

		failures = dut.outCheck.failCount;
		$display("Summary: %0d phases run, %0d assertion failures", phaseCount, failures);
		if (failures == 0) begin
			$display("all tests passed");
		end else begin
			$display("tests failed");
		end
		$finish;
	end

endmodule

// File: build.f
+incdir+design
design/decodePkg.sv
design/ctrlBundleIf.sv
design/instrClassifier.sv
design/aluOpDecoder.sv
design/memOpDecoder.sv
design/flowDecoder.sv
design/stackDecoder.sv
design/ctrlRegister.sv
design/controlUnit.sv
dv/controlUnit_checker.sv
dv/controlUnitTb.sv

// File: run.sh
#!/usr/bin/env bash
# Build and run the decode stage testbench with Verilator

cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log

verilator --binary --timing --assert -f build.f --top-module controlUnitTb -o controlUnitSim \
	&& ./obj_dir/controlUnitSim +verilator+error+limit+100000 > sim.log 2>&1

cat sim.log 2>/dev/null
grep -q "tests failed" sim.log && { echo "Simulation FAILED"; exit 1; }
grep -q "all tests passed" sim.log || { echo "No result found in sim.log"; exit 1; }
echo "Simulation PASSED"
